// ==== rtl/scalar_pkg.sv ====
// Types, instruction fields and opcodes of the scalar issue unit, imported by every RTL module
`default_nettype none

package scalar_pkg;

	// Data path
	localparam int DATA_W = 32;
	typedef logic [DATA_W-1:0] data_t;

	// Register file size and index
	localparam int REG_N = 32;
	typedef logic [$clog2(REG_N)-1:0] reg_idx_t;

	// Issue-order tag, wraps around
	localparam int ISSUE_W = 4;
	typedef logic [ISSUE_W-1:0] issue_no_t;

	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_LDI  = 4'h5,
		OP_HALT = 4'hF
	} opcode_t;

	typedef struct packed {
		logic        sel_unit;	// 1 sends the word to the vector unit
		opcode_t     op;
		reg_idx_t    dst;
		reg_idx_t    src1;
		reg_idx_t    src2;
		logic [11:0] imm;
	} instr_t;

	// Scalar reorder entry, result known at push
	typedef struct packed {
		reg_idx_t dst;
		data_t    data;
	} s_entry_t;

	// Vector reorder entry, data comes back later
	typedef struct packed {
		reg_idx_t dst;
	} v_entry_t;

endpackage

`default_nettype wire

// ==== rtl/instr_mem.sv ====
// Instruction memory, filled word by word through the store handshake and read by fetch
`default_nettype none
`timescale 1ns/100ps

module instr_mem #(
	parameter int INSTR_DEPTH = 64
) (
	input  wire                             clock,
	input  wire                             reset,
	input  wire                             start,
	input  wire                             busy,
	input  wire                             req_st,
	input  wire  scalar_pkg::instr_t        instr_in,
	output logic                            ack_st,
	input  wire                             fetch_en,
	input  wire  [$clog2(INSTR_DEPTH)-1:0]  fetch_addr,
	output scalar_pkg::instr_t              fetch_instr
);

	import scalar_pkg::*;

	instr_t                         mem [INSTR_DEPTH];
	logic [$clog2(INSTR_DEPTH)-1:0] st_addr;
	logic                           st_take;

	// A raised ack keeps the same word from being taken twice
	assign st_take = req_st & ~ack_st & ~busy;

	always_ff @(posedge clock) begin
		if (reset) begin
			ack_st  <= 1'b0;
			st_addr <= '0;
		end else begin
			ack_st <= st_take;
			if (start) begin
				st_addr <= '0;
			end else if (st_take) begin
				st_addr <= st_addr + 1'b1;
			end
		end
	end

	// Store port and synchronous fetch port
	always_ff @(posedge clock) begin
		if (st_take) begin
			mem[st_addr] <= instr_in;
		end
		if (fetch_en) begin
			fetch_instr <= mem[fetch_addr];
		end
	end

	// Loader stays quiet while the program runs
	assert property (@(posedge clock) disable iff (reset) busy |-> !req_st)
		else $error("instr_mem: store request while busy");

endmodule

`default_nettype wire

// ==== rtl/fetch_issue.sv ====
// Fetch and issue stage: PC, scoreboard, issue numbering, scalar/vector dispatch, termination
`default_nettype none
`timescale 1ns/100ps

module fetch_issue #(
	parameter int INSTR_DEPTH = 64
) (
	input  wire                             clock,
	input  wire                             reset,
	input  wire                             start,
	output logic                            fetch_en,
	output logic [$clog2(INSTR_DEPTH)-1:0]  fetch_addr,
	input  wire  scalar_pkg::instr_t        fetch_instr,
	output scalar_pkg::reg_idx_t            rd_idx1,
	output scalar_pkg::reg_idx_t            rd_idx2,
	output logic                            s_issue_valid,
	output scalar_pkg::instr_t              s_issue_instr,
	output scalar_pkg::issue_no_t           s_issue_no,
	output logic                            v_push,
	output scalar_pkg::v_entry_t            v_push_entry,
	output scalar_pkg::issue_no_t           v_push_no,
	input  wire                             s_full,
	input  wire                             v_full,
	input  wire                             release_valid,
	input  wire  scalar_pkg::reg_idx_t      release_dst,
	input  wire                             rb_empty,
	output logic                            v_cmd_valid,
	output scalar_pkg::instr_t              v_cmd,
	output logic                            busy,
	output logic                            term
);

	import scalar_pkg::*;

	logic [$clog2(INSTR_DEPTH)-1:0] pc;
	logic                           running;
	logic                           halted;
	logic                           word_valid;	// fetch_instr holds an unissued word
	logic                           s_inflight;
	logic [REG_N-1:0]               pending;
	issue_no_t                      issue_cnt;
	logic                           is_halt;
	logic                           hazard;
	logic                           room;
	logic                           issue;

	////////////////////////////////////////////////////////////////////////////
	// Issue decision

	assign is_halt = word_valid & ~fetch_instr.sel_unit & (fetch_instr.op == OP_HALT);
	assign hazard  = pending[fetch_instr.src1] | pending[fetch_instr.src2]
		| pending[fetch_instr.dst];

	// Scalar result lands a cycle after issue, keep its slot free
	assign room  = fetch_instr.sel_unit ? ~v_full : (~s_full & ~s_inflight);
	assign issue = word_valid & ~is_halt & ~hazard & room;

	// Fetch when the word slot is empty or being consumed
	assign fetch_en   = running & (~word_valid | issue);
	assign fetch_addr = pc;

	assign rd_idx1       = fetch_instr.src1;
	assign rd_idx2       = fetch_instr.src2;
	assign s_issue_valid = issue & ~fetch_instr.sel_unit;
	assign s_issue_instr = fetch_instr;
	assign s_issue_no    = issue_cnt;
	assign v_push        = issue & fetch_instr.sel_unit;
	assign v_push_entry  = '{dst: fetch_instr.dst};
	assign v_push_no     = issue_cnt;
	assign v_cmd_valid   = v_push;
	assign v_cmd         = fetch_instr;

	////////////////////////////////////////////////////////////////////////////
	// Sequencing

	always_ff @(posedge clock) begin
		if (reset) begin
			pc         <= '0;
			running    <= 1'b0;
			halted     <= 1'b0;
			word_valid <= 1'b0;
			s_inflight <= 1'b0;
			issue_cnt  <= '0;
			busy       <= 1'b0;
			term       <= 1'b0;
		end else if (start) begin
			pc         <= '0;
			running    <= 1'b1;
			halted     <= 1'b0;
			word_valid <= 1'b0;
			s_inflight <= 1'b0;
			issue_cnt  <= '0;
			busy       <= 1'b1;
			term       <= 1'b0;
		end else begin
			s_inflight <= s_issue_valid;
			if (fetch_en) begin
				pc         <= pc + 1'b1;
				word_valid <= 1'b1;
			end else if (issue | is_halt) begin
				word_valid <= 1'b0;
			end
			if (issue) begin
				issue_cnt <= issue_cnt + 1'b1;
			end
			if (is_halt) begin
				running <= 1'b0;
				halted  <= 1'b1;
			end
			// Drained, every issued instruction has committed
			if (halted & rb_empty) begin
				halted <= 1'b0;
				busy   <= 1'b0;
				term   <= 1'b1;
			end
		end
	end

	// Scoreboard, one pending bit per register
	always_ff @(posedge clock) begin
		if (reset | start) begin
			pending <= '0;
		end else begin
			if (release_valid) begin
				pending[release_dst] <= 1'b0;
			end
			if (issue) begin
				pending[fetch_instr.dst] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// Scalar register file with two combinational read ports and one commit write port
`default_nettype none
`timescale 1ns/100ps

module reg_file (
	input  wire                         clock,
	input  wire                         reset,
	input  wire  scalar_pkg::reg_idx_t  rd_idx1,
	input  wire  scalar_pkg::reg_idx_t  rd_idx2,
	output scalar_pkg::data_t           rd_data1,
	output scalar_pkg::data_t           rd_data2,
	input  wire                         wr_en,
	input  wire  scalar_pkg::reg_idx_t  wr_idx,
	input  wire  scalar_pkg::data_t     wr_data
);

	import scalar_pkg::*;

	data_t regs [REG_N];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Write lands at the edge, visible to the next issue
	assign rd_data1 = regs[rd_idx1];
	assign rd_data2 = regs[rd_idx2];

endmodule

`default_nettype wire

// ==== rtl/exec_scalar.sv ====
// One-cycle scalar ALU, turns an issued instruction into a tagged result for the reorder buffer
`default_nettype none
`timescale 1ns/100ps

module exec_scalar (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          s_issue_valid,
	input  wire  scalar_pkg::instr_t     s_issue_instr,
	input  wire  scalar_pkg::issue_no_t  s_issue_no,
	input  wire  scalar_pkg::data_t      rd_data1,
	input  wire  scalar_pkg::data_t      rd_data2,
	output logic                         s_res_valid,
	output scalar_pkg::issue_no_t        s_res_no,
	output scalar_pkg::s_entry_t         s_res_entry
);

	import scalar_pkg::*;

	data_t imm_ext;
	data_t result;

	assign imm_ext = {{(DATA_W - 12){s_issue_instr.imm[11]}}, s_issue_instr.imm};

	always_comb begin
		case (s_issue_instr.op)
			OP_ADD:  result = rd_data1 + rd_data2;
			OP_SUB:  result = rd_data1 - rd_data2;
			OP_AND:  result = rd_data1 & rd_data2;
			OP_OR:   result = rd_data1 | rd_data2;
			OP_XOR:  result = rd_data1 ^ rd_data2;
			OP_LDI:  result = imm_ext;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			s_res_valid <= 1'b0;
		end else begin
			s_res_valid <= s_issue_valid;
		end
	end

	// Result and its tag
	always_ff @(posedge clock) begin
		if (s_issue_valid) begin
			s_res_no    <= s_issue_no;
			s_res_entry <= '{dst: s_issue_instr.dst, data: result};
		end
	end

endmodule

`default_nettype wire

// ==== rtl/reorder_buff.sv ====
// In-order entry buffer with completion tracking, holds scalar results or pending vector commands
`default_nettype none
`timescale 1ns/100ps

module reorder_buff #(
	parameter type payload_t = logic,
	parameter int  RB_DEPTH  = 4
) (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          push,
	input  wire  scalar_pkg::issue_no_t  push_no,
	input  wire  payload_t               push_entry,
	input  wire                          complete,
	input  wire  scalar_pkg::data_t      complete_data,
	input  wire                          pop,
	output logic                         head_valid,
	output scalar_pkg::issue_no_t        head_no,
	output payload_t                     head_entry,
	output logic                         head_done,
	output scalar_pkg::data_t            head_data,
	output logic                         full,
	output logic                         empty
);

	import scalar_pkg::*;

	localparam int PW = (RB_DEPTH > 1) ? $clog2(RB_DEPTH) : 1;

	issue_no_t           no_q    [RB_DEPTH];
	payload_t            entry_q [RB_DEPTH];
	data_t               data_q  [RB_DEPTH];
	logic [RB_DEPTH-1:0] done_q;
	logic [PW-1:0]       wr_ptr;
	logic [PW-1:0]       rd_ptr;
	logic [PW-1:0]       cmp_ptr;	// oldest entry not yet done
	logic [PW:0]         count;

	function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
		return (ptr == PW'(RB_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			cmp_ptr <= '0;
			count   <= '0;
			done_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr         <= ptr_inc(wr_ptr);
				done_q[wr_ptr] <= 1'b0;
			end
			// Completion after push, so a push with complete lands done
			if (complete) begin
				cmp_ptr         <= ptr_inc(cmp_ptr);
				done_q[cmp_ptr] <= 1'b1;
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + (PW + 1)'(push) - (PW + 1)'(pop);
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			no_q[wr_ptr]    <= push_no;
			entry_q[wr_ptr] <= push_entry;
		end
		if (complete) begin
			data_q[cmp_ptr] <= complete_data;
		end
	end

	assign head_valid = ~empty;
	assign head_no    = no_q[rd_ptr];
	assign head_entry = entry_q[rd_ptr];
	assign head_done  = done_q[rd_ptr];
	assign head_data  = data_q[rd_ptr];
	assign full       = (count == (PW + 1)'(RB_DEPTH));
	assign empty      = (count == '0);

	// Issue side honours full, commit side only pops a live head
	assert property (@(posedge clock) disable iff (reset) !(push && full) && !(pop && empty))
		else $error("reorder_buff: push while full or pop while empty");

endmodule

`default_nettype wire

// ==== rtl/commit_arbiter.sv ====
// Commit arbiter, pops the buffer head with the next issue number and writes it back
`default_nettype none
`timescale 1ns/100ps

module commit_arbiter (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          start,
	input  wire                          s_head_valid,
	input  wire  scalar_pkg::issue_no_t  s_head_no,
	input  wire                          s_head_done,
	input  wire  scalar_pkg::s_entry_t   s_head_entry,
	input  wire                          v_head_valid,
	input  wire  scalar_pkg::issue_no_t  v_head_no,
	input  wire                          v_head_done,
	input  wire  scalar_pkg::v_entry_t   v_head_entry,
	input  wire  scalar_pkg::data_t      v_head_data,
	output logic                         pop_s,
	output logic                         pop_v,
	output logic                         wr_en,
	output scalar_pkg::reg_idx_t         wr_idx,
	output scalar_pkg::data_t            wr_data,
	output logic                         release_valid,
	output scalar_pkg::reg_idx_t         release_dst,
	output logic                         commit_valid,
	output scalar_pkg::issue_no_t        commit_no,
	output scalar_pkg::reg_idx_t         commit_dst,
	output scalar_pkg::data_t            commit_data
);

	import scalar_pkg::*;

	issue_no_t next_no;

	// Only the head carrying the expected number may commit
	assign pop_s = s_head_valid & s_head_done & (s_head_no == next_no);
	assign pop_v = v_head_valid & v_head_done & (v_head_no == next_no);

	assign wr_en         = pop_s | pop_v;
	assign wr_idx        = pop_s ? s_head_entry.dst : v_head_entry.dst;
	assign wr_data       = pop_s ? s_head_entry.data : v_head_data;
	assign release_valid = wr_en;
	assign release_dst   = wr_idx;

	always_ff @(posedge clock) begin
		if (reset | start) begin
			next_no <= '0;
		end else if (wr_en) begin
			next_no <= next_no + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= wr_en;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			commit_no   <= next_no;
			commit_dst  <= wr_idx;
			commit_data <= wr_data;
		end
	end

	// Issue numbers are unique across both buffers
	assert property (@(posedge clock) disable iff (reset) !(pop_s && pop_v))
		else $error("commit_arbiter: both buffers granted in one cycle");

endmodule

`default_nettype wire

// ==== rtl/scalar_unit.sv ====
// Top level of the scalar issue unit, connects storage, issue, ALU, reorder buffers and commit
`default_nettype none
`timescale 1ns/100ps

module scalar_unit #(
	parameter int INSTR_DEPTH = 64,
	parameter int RB_DEPTH    = 4
) (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          start,
	input  wire                          req_st,
	input  wire  scalar_pkg::instr_t     instr_in,
	output logic                         ack_st,
	output logic                         v_cmd_valid,
	output scalar_pkg::instr_t           v_cmd,
	input  wire                          v_done,
	input  wire  scalar_pkg::data_t      v_data,
	output logic                         commit_valid,
	output scalar_pkg::issue_no_t        commit_no,
	output scalar_pkg::reg_idx_t         commit_dst,
	output scalar_pkg::data_t            commit_data,
	output logic                         busy,
	output logic                         term
);

	import scalar_pkg::*;

	logic                           fetch_en;
	logic [$clog2(INSTR_DEPTH)-1:0] fetch_addr;
	instr_t                         fetch_instr;
	reg_idx_t                       rd_idx1, rd_idx2;
	data_t                          rd_data1, rd_data2;
	logic                           s_issue_valid;
	instr_t                         s_issue_instr;
	issue_no_t                      s_issue_no;
	logic                           v_push;
	v_entry_t                       v_push_entry;
	issue_no_t                      v_push_no;
	logic                           s_res_valid;
	issue_no_t                      s_res_no;
	s_entry_t                       s_res_entry;
	logic                           s_head_valid, s_head_done, s_full, s_empty, pop_s;
	issue_no_t                      s_head_no;
	s_entry_t                       s_head_entry;
	logic                           v_head_valid, v_head_done, v_full, v_empty, pop_v;
	issue_no_t                      v_head_no;
	v_entry_t                       v_head_entry;
	data_t                          v_head_data;
	logic                           wr_en, release_valid;
	reg_idx_t                       wr_idx, release_dst;
	data_t                          wr_data;

	////////////////////////////////////////////////////////////////////////////
	// Front end

	instr_mem #(.INSTR_DEPTH(INSTR_DEPTH)) u_imem (
		.clock(clock), .reset(reset), .start(start), .busy(busy),
		.req_st(req_st), .instr_in(instr_in), .ack_st(ack_st),
		.fetch_en(fetch_en), .fetch_addr(fetch_addr), .fetch_instr(fetch_instr)
	);

	fetch_issue #(.INSTR_DEPTH(INSTR_DEPTH)) u_issue (
		.clock(clock), .reset(reset), .start(start),
		.fetch_en(fetch_en), .fetch_addr(fetch_addr), .fetch_instr(fetch_instr),
		.rd_idx1(rd_idx1), .rd_idx2(rd_idx2),
		.s_issue_valid(s_issue_valid), .s_issue_instr(s_issue_instr), .s_issue_no(s_issue_no),
		.v_push(v_push), .v_push_entry(v_push_entry), .v_push_no(v_push_no),
		.s_full(s_full), .v_full(v_full),
		.release_valid(release_valid), .release_dst(release_dst),
		.rb_empty(s_empty & v_empty),
		.v_cmd_valid(v_cmd_valid), .v_cmd(v_cmd), .busy(busy), .term(term)
	);

	////////////////////////////////////////////////////////////////////////////
	// Scalar back end and reorder buffers

	reg_file u_rf (
		.clock(clock), .reset(reset),
		.rd_idx1(rd_idx1), .rd_idx2(rd_idx2), .rd_data1(rd_data1), .rd_data2(rd_data2),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
	);

	exec_scalar u_exec (
		.clock(clock), .reset(reset),
		.s_issue_valid(s_issue_valid), .s_issue_instr(s_issue_instr), .s_issue_no(s_issue_no),
		.rd_data1(rd_data1), .rd_data2(rd_data2),
		.s_res_valid(s_res_valid), .s_res_no(s_res_no), .s_res_entry(s_res_entry)
	);

	// Scalar entries arrive already done
	reorder_buff #(.payload_t(s_entry_t), .RB_DEPTH(RB_DEPTH)) rb_scalar (
		.clock(clock), .reset(reset),
		.push(s_res_valid), .push_no(s_res_no), .push_entry(s_res_entry),
		.complete(s_res_valid), .complete_data(s_res_entry.data), .pop(pop_s),
		.head_valid(s_head_valid), .head_no(s_head_no), .head_entry(s_head_entry),
		.head_done(s_head_done), .head_data(), .full(s_full), .empty(s_empty)
	);

	// Each v_done finishes the oldest outstanding command
	reorder_buff #(.payload_t(v_entry_t), .RB_DEPTH(RB_DEPTH)) rb_vector (
		.clock(clock), .reset(reset),
		.push(v_push), .push_no(v_push_no), .push_entry(v_push_entry),
		.complete(v_done), .complete_data(v_data), .pop(pop_v),
		.head_valid(v_head_valid), .head_no(v_head_no), .head_entry(v_head_entry),
		.head_done(v_head_done), .head_data(v_head_data), .full(v_full), .empty(v_empty)
	);

	commit_arbiter u_commit (
		.clock(clock), .reset(reset), .start(start),
		.s_head_valid(s_head_valid), .s_head_no(s_head_no),
		.s_head_done(s_head_done), .s_head_entry(s_head_entry),
		.v_head_valid(v_head_valid), .v_head_no(v_head_no), .v_head_done(v_head_done),
		.v_head_entry(v_head_entry), .v_head_data(v_head_data),
		.pop_s(pop_s), .pop_v(pop_v),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.release_valid(release_valid), .release_dst(release_dst),
		.commit_valid(commit_valid), .commit_no(commit_no),
		.commit_dst(commit_dst), .commit_data(commit_data)
	);

endmodule

`default_nettype wire

// ==== tb/tb_scalar_unit.sv ====
// Testbench for the scalar issue unit that loads a program table, runs it and checks every commit
`default_nettype none
`timescale 1ns/100ps

module tb_scalar_unit;

	import scalar_pkg::*;

	localparam int ROWS           = 20;
	localparam int TIMEOUT_CYCLES = 200 * ROWS;

	logic      clock = 1'b0;
	logic      reset;
	logic      start;
	logic      req_st;
	instr_t    instr_in;
	logic      ack_st;
	logic      v_cmd_valid;
	instr_t    v_cmd;
	logic      v_done;
	data_t     v_data;
	logic      commit_valid;
	issue_no_t commit_no;
	reg_idx_t  commit_dst;
	data_t     commit_data;
	logic      busy;
	logic      term;

	// Program table and the model's expected results
	instr_t   prog      [ROWS];
	data_t    vec_reply [ROWS];
	reg_idx_t exp_dst   [ROWS];
	data_t    exp_data  [ROWS];

	data_t reply_q [$];
	int    commit_count = 0;
	int    ack_count    = 0;
	int    vec_ptr      = 0;
	int    cycle_count  = 0;
	logic  started      = 1'b0;

	scalar_unit #(.INSTR_DEPTH(64), .RB_DEPTH(4)) dut0 (
		.clock(clock), .reset(reset), .start(start),
		.req_st(req_st), .instr_in(instr_in), .ack_st(ack_st),
		.v_cmd_valid(v_cmd_valid), .v_cmd(v_cmd), .v_done(v_done), .v_data(v_data),
		.commit_valid(commit_valid), .commit_no(commit_no),
		.commit_dst(commit_dst), .commit_data(commit_data),
		.busy(busy), .term(term)
	);

	always #20 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Reporting and compare tasks

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED at %0t: %s got %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED at %0t: %s got %0d, expected %0d",
				$time, name, got, exp));
		end
	endtask

	task automatic check_no(input string name, input issue_no_t got, input issue_no_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED at %0t: %s got %0d, expected %0d",
				$time, name, got, exp));
		end
	endtask

	task automatic check_instr(input string name, input instr_t got, input instr_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED at %0t: %s got %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Program table and register model

	function automatic instr_t encode_instr(input logic vec, input opcode_t op, input int dst,
		input int s1, input int s2, input logic [11:0] imm);
		instr_t w;
		w.sel_unit = vec;
		w.op       = op;
		w.dst      = reg_idx_t'(dst);
		w.src1     = reg_idx_t'(s1);
		w.src2     = reg_idx_t'(s2);
		w.imm      = imm;
		return w;
	endfunction

	// Dependent chains first and then vector commands mixed with scalar work
	task automatic build_program;
		prog[0]  = encode_instr(1'b0, OP_LDI, 1, 0, 0, 12'h0A6);
		prog[1]  = encode_instr(1'b0, OP_LDI, 2, 0, 0, 12'hFFD);
		prog[2]  = encode_instr(1'b0, OP_ADD, 3, 1, 2, 12'd0);
		prog[3]  = encode_instr(1'b0, OP_SUB, 4, 3, 1, 12'd0);
		prog[4]  = encode_instr(1'b0, OP_AND, 5, 4, 1, 12'd0);
		prog[5]  = encode_instr(1'b0, OP_OR, 6, 5, 3, 12'd0);
		prog[6]  = encode_instr(1'b0, OP_XOR, 7, 6, 2, 12'd0);
		prog[7]  = encode_instr(1'b1, OP_ADD, 8, 1, 2, 12'd0);
		prog[8]  = encode_instr(1'b0, OP_ADD, 9, 8, 1, 12'd0);
		prog[9]  = encode_instr(1'b1, OP_SUB, 10, 3, 4, 12'h123);
		prog[10] = encode_instr(1'b1, OP_XOR, 11, 5, 6, 12'd0);
		prog[11] = encode_instr(1'b0, OP_LDI, 12, 0, 0, 12'h7FF);
		prog[12] = encode_instr(1'b1, OP_OR, 13, 7, 7, 12'd0);
		prog[13] = encode_instr(1'b0, OP_ADD, 14, 12, 12, 12'd0);
		prog[14] = encode_instr(1'b1, OP_AND, 15, 1, 1, 12'h0F0);
		prog[15] = encode_instr(1'b0, OP_XOR, 16, 14, 9, 12'd0);
		prog[16] = encode_instr(1'b1, OP_ADD, 8, 2, 3, 12'd0);
		prog[17] = encode_instr(1'b0, OP_SUB, 17, 16, 8, 12'd0);
		prog[18] = encode_instr(1'b0, OP_LDI, 18, 0, 0, 12'h800);
		prog[19] = encode_instr(1'b0, OP_HALT, 0, 0, 0, 12'd0);
		// Reply data used only by vector rows
		for (int i = 0; i < ROWS; i++) begin
			vec_reply[i] = 32'h5A00_0000 ^ (32'(i) * 32'h0001_1011);
		end
	endtask

	task automatic compute_expected;
		data_t model_rf [REG_N];
		data_t a;
		data_t b;
		data_t r;
		for (int i = 0; i < REG_N; i++) begin
			model_rf[i] = '0;
		end
		for (int i = 0; i < ROWS; i++) begin
			a = model_rf[prog[i].src1];
			b = model_rf[prog[i].src2];
			if (prog[i].sel_unit) begin
				r = vec_reply[i];
			end else begin
				case (prog[i].op)
					OP_ADD:  r = a + b;
					OP_SUB:  r = a - b;
					OP_AND:  r = a & b;
					OP_OR:   r = a | b;
					OP_XOR:  r = a ^ b;
					OP_LDI:  r = {{20{prog[i].imm[11]}}, prog[i].imm};
					default: r = '0;
				endcase
			end
			exp_dst[i]  = prog[i].dst;
			exp_data[i] = r;
			if (prog[i].sel_unit || prog[i].op != OP_HALT) begin
				model_rf[prog[i].dst] = r;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Loader, monitors and vector unit model

	task automatic load_program;
		for (int i = 0; i < ROWS; i++) begin
			@(posedge clock);
			#2;
			req_st   = 1'b1;
			instr_in = prog[i];
			@(negedge clock);
			while (!ack_st) begin
				@(negedge clock);
			end
		end
		@(posedge clock);
		#2;
		req_st = 1'b0;
	endtask

	task automatic check_vector_cmd;
		while (vec_ptr < ROWS && !prog[vec_ptr].sel_unit) begin
			vec_ptr++;
		end
		if (vec_ptr >= ROWS) begin
			stop_with_error("Vector command issued with no vector row left in the program");
		end else begin
			check_instr("v_cmd", v_cmd, prog[vec_ptr]);
			reply_q.push_back(vec_reply[vec_ptr]);
			vec_ptr++;
		end
	endtask

	task automatic check_commit;
		if (commit_count >= ROWS - 1) begin
			stop_with_error("Commit seen after every instruction before HALT had committed");
		end else begin
			check_no("commit_no", commit_no, issue_no_t'(commit_count));
			check_idx("commit_dst", commit_dst, exp_dst[commit_count]);
			check_data("commit_data", commit_data, exp_data[commit_count]);
			commit_count++;
		end
	endtask

	always @(negedge clock) begin
		if (!reset) begin
			if (ack_st) begin
				ack_count++;
			end
			if (busy && !started) begin
				stop_with_error("busy rose before start");
			end
			if (v_cmd_valid) begin
				check_vector_cmd();
			end
			if (commit_valid) begin
				check_commit();
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			stop_with_error("Timeout, commits stopped before the program reached its end");
		end
	end

	// Replies in command order 1 to 6 cycles after each command
	initial begin : vector_unit
		data_t       reply;
		int unsigned delay;
		void'($urandom(86754));
		v_done = 1'b0;
		v_data = '0;
		forever begin
			@(posedge clock);
			if (reply_q.size() > 0) begin
				reply = reply_q.pop_front();
				delay = $urandom_range(6, 1);
				repeat (delay - 1) @(posedge clock);
				#2;
				v_done = 1'b1;
				v_data = reply;
				@(posedge clock);
				#2;
				v_done = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		reset    = 1'b1;
		start    = 1'b0;
		req_st   = 1'b0;
		instr_in = '0;
		build_program();
		compute_expected();
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		@(negedge clock);
		if (ack_st || busy || term || commit_valid || v_cmd_valid) begin
			stop_with_error("Outputs not idle after reset");
		end
		load_program();
		repeat (2) @(negedge clock);
		#1;
		if (ack_count != ROWS) begin
			stop_with_error($sformatf("Loader saw %0d acks for %0d stores", ack_count, ROWS));
		end
		@(posedge clock);
		#2;
		start   = 1'b1;
		started = 1'b1;
		@(posedge clock);
		#2;
		start = 1'b0;
		@(negedge clock);
		while (!term) begin
			@(negedge clock);
		end
		if (busy) begin
			stop_with_error("busy still high when term rose");
		end
		// No commit may follow HALT
		repeat (10) @(negedge clock);
		#1;
		if (commit_count != ROWS - 1) begin
			stop_with_error("term rose before every instruction had committed");
		end
		if (!term || busy) begin
			stop_with_error("term or busy changed after the program ended");
		end
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== scalar_unit.f ====
rtl/scalar_pkg.sv
rtl/instr_mem.sv
rtl/fetch_issue.sv
rtl/reg_file.sv
rtl/exec_scalar.sv
rtl/reorder_buff.sv
rtl/commit_arbiter.sv
rtl/scalar_unit.sv
tb/tb_scalar_unit.sv

// ==== Makefile ====
# Verilator simulation of the scalar issue unit

TOP := tb_scalar_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f scalar_unit.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
